//--- include/cdc_defines.svh
// cdc bridge build-time constants
// widths of the request and response channels, depth of the crossing
// FIFOs, the pending transaction limit and the synchronizer length
`ifndef CDC_DEFINES_SVH
`define CDC_DEFINES_SVH

// request address and data widths, strobe width follows the data
`define CDC_ADDR_W 16
`define CDC_DATA_W 32

// each FIFO holds 2**CDC_LOG_DEPTH entries
`define CDC_LOG_DEPTH 2
`define CDC_MAX_PENDING 8
`define CDC_SYNC_STAGES 2

`endif

//--- src/cdc_pkg.sv
// cdc bridge types
// request and response channel structs for the folded AXI-Lite bus,
// the clear sequencer phase encoding and the pointer and counter types
`default_nettype none
`include "cdc_defines.svh"

package cdc_pkg;

  // one request beat carries address, direction, write data and strobes
  typedef struct packed {
    logic [`CDC_ADDR_W-1:0]   addr;
    logic                     write;
    logic [`CDC_DATA_W-1:0]   wdata;
    logic [`CDC_DATA_W/8-1:0] strb;
  } req_chan_t;

  // err is set by the slave for a rejected access, rdata is unused on writes
  typedef struct packed {
    logic [`CDC_DATA_W-1:0] rdata;
    logic                   err;
  } rsp_chan_t;

  // phases of the lock-step clear, in the order they are visited
  typedef enum logic [1:0] {
    clr_idle    = 2'd0,
    clr_isolate = 2'd1,
    clr_clear   = 2'd2,
    clr_post    = 2'd3
  } clr_phase_e;

  // fifo pointers carry one wrap bit above the index
  typedef logic [`CDC_LOG_DEPTH:0] fifo_ptr_t;
  // the pending counter has to reach CDC_MAX_PENDING itself
  typedef logic [$clog2(`CDC_MAX_PENDING+1)-1:0] pend_cnt_t;

endpackage

`default_nettype wire

//--- src/cdc_fifo_gray.sv
// clearable dual-clock FIFO
// storage is written under the push clock and read under the pop clock,
// gray-coded pointers cross through a chain of synchronizer flops
// each side can be cleared on its own clock, which returns its pointers
// to zero; both sides must be cleared while the bus is quiet
`timescale 1ns/1ns
`default_nettype none
`include "cdc_defines.svh"

module cdc_fifo_gray #(
  parameter type payload_t = logic
) (
  input  wire logic      push_clk_i,
  input  wire logic      push_rst_i,
  input  wire logic      push_clr_i,
  input  wire logic      push_valid_i,
  input  wire payload_t  push_data_i,
  output logic           push_ready_o,
  input  wire logic      pop_clk_i,
  input  wire logic      pop_rst_i,
  input  wire logic      pop_clr_i,
  output logic           pop_valid_o,
  output payload_t       pop_data_o,
  input  wire logic      pop_ready_i
);
  import cdc_pkg::*;

  localparam int depth = 2 ** `CDC_LOG_DEPTH;
  localparam int last_stage = `CDC_SYNC_STAGES - 1;
  // full means the two top gray bits differ and the rest match
  localparam fifo_ptr_t full_xor = fifo_ptr_t'(3) << (`CDC_LOG_DEPTH - 1);

  // storage, written only on the push side
  payload_t mem_q [depth];

  // push side pointers and the synchronized read pointer
  fifo_ptr_t wptr_bin_q;
  fifo_ptr_t wptr_bin_d;
  fifo_ptr_t wptr_gray_q;
  fifo_ptr_t rptr_sync_q [`CDC_SYNC_STAGES];
  logic      push_fire;

  // pop side pointers and the synchronized write pointer
  fifo_ptr_t rptr_bin_q;
  fifo_ptr_t rptr_bin_d;
  fifo_ptr_t rptr_gray_q;
  fifo_ptr_t wptr_sync_q [`CDC_SYNC_STAGES];
  logic      pop_fire;

  function automatic fifo_ptr_t bin2gray(input fifo_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // the read pointer seen here lags by the synchronizer length, so full is
  // pessimistic and space reappears a few push clocks after a pop
  assign push_ready_o = ((wptr_gray_q ^ rptr_sync_q[last_stage]) != full_xor) && !push_clr_i;
  assign push_fire    = push_valid_i && push_ready_o;
  assign wptr_bin_d   = wptr_bin_q + fifo_ptr_t'(push_fire);

  always_ff @(posedge push_clk_i) begin
    if (push_fire) begin
      mem_q[wptr_bin_q[`CDC_LOG_DEPTH-1:0]] <= push_data_i;
    end
  end

  always_ff @(posedge push_clk_i) begin
    if (push_rst_i || push_clr_i) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
      for (int i = 0; i < `CDC_SYNC_STAGES; i++) begin
        rptr_sync_q[i] <= '0;
      end
    end else begin
      wptr_bin_q     <= wptr_bin_d;
      wptr_gray_q    <= bin2gray(wptr_bin_d);
      // only one gray bit moves per pop, so the chain never sees a torn value
      rptr_sync_q[0] <= rptr_gray_q;
      for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
        rptr_sync_q[i] <= rptr_sync_q[i-1];
      end
    end
  end

  // empty when our read pointer has caught up with the delayed write pointer
  assign pop_valid_o = (rptr_gray_q != wptr_sync_q[last_stage]) && !pop_clr_i;
  assign pop_fire    = pop_valid_o && pop_ready_i;
  assign rptr_bin_d  = rptr_bin_q + fifo_ptr_t'(pop_fire);
  // the head entry is stable once its write pointer has been synchronized
  assign pop_data_o  = mem_q[rptr_bin_q[`CDC_LOG_DEPTH-1:0]];

  always_ff @(posedge pop_clk_i) begin
    if (pop_rst_i || pop_clr_i) begin
      rptr_bin_q  <= '0;
      rptr_gray_q <= '0;
      for (int i = 0; i < `CDC_SYNC_STAGES; i++) begin
        wptr_sync_q[i] <= '0;
      end
    end else begin
      rptr_bin_q     <= rptr_bin_d;
      rptr_gray_q    <= bin2gray(rptr_bin_d);
      wptr_sync_q[0] <= wptr_gray_q;
      for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
        wptr_sync_q[i] <= wptr_sync_q[i-1];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/cdc_isolate.sv
// source-side request gate
// counts requests pushed into the crossing and responses popped from it,
// blocks new requests while isolation is asked for or the pending
// limit is reached, and reports idle once nothing is outstanding
`timescale 1ns/1ns
`default_nettype none
`include "cdc_defines.svh"

module cdc_isolate (
  input  wire logic src_clk_i,
  input  wire logic rst_i,
  input  wire logic isolate_i,
  input  wire logic req_valid_i,
  output logic      req_ready_o,
  output logic      fifo_valid_o,
  input  wire logic fifo_ready_i,
  input  wire logic rsp_pop_i,
  output logic      idle_o
);
  import cdc_pkg::*;

  localparam pend_cnt_t max_cnt = pend_cnt_t'(`CDC_MAX_PENDING);

  pend_cnt_t cnt_q;
  logic      block;
  logic      accept;

  // block only depends on flops and the isolate request, so the
  // request path stays purely combinational and adds no cycle
  assign block = isolate_i || (cnt_q == max_cnt);

  // valid is withheld from the FIFO while blocked so no beat slips in
  assign fifo_valid_o = req_valid_i && !block;
  assign req_ready_o  = fifo_ready_i && !block;
  assign accept       = fifo_valid_o && fifo_ready_i;

  // every accepted request gets exactly one response, so the
  // counter returns to zero once the bus has drained
  always_ff @(posedge src_clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (accept && !rsp_pop_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (!accept && rsp_pop_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // the clear sequencer waits on this before touching the FIFOs
  assign idle_o = (cnt_q == '0);

endmodule

`default_nettype wire

//--- src/cdc_clear_seq.sv
// lock-step clear sequencer for both sides of the crossing
// the source FSM isolates the port, waits until it drains, clears its own
// FIFO ends and passes the clear phase across with a four-phase req/ack
// handshake, the destination responder clears its ends while it sees it
`timescale 1ns/1ns
`default_nettype none
`include "cdc_defines.svh"

module cdc_clear_seq (
  input  wire logic src_clk_i,
  input  wire logic rst_i,
  input  wire logic src_clear_i,
  input  wire logic idle_i,
  output logic      isolate_o,
  output logic      src_clr_o,
  output logic      busy_o,
  input  wire logic dst_clk_i,
  input  wire logic dst_rst_i,
  output logic      dst_clr_o
);
  import cdc_pkg::*;

  localparam int last_stage = `CDC_SYNC_STAGES - 1;

  // source domain
  clr_phase_e                  phase_q;
  logic                        req_q;
  logic                        sent_q;
  logic [`CDC_SYNC_STAGES-1:0] ack_sync_q;
  logic                        ack_s;

  // destination domain
  logic [`CDC_SYNC_STAGES-1:0] req_sync_q;
  clr_phase_e                  phase_sync_q [`CDC_SYNC_STAGES];
  logic                        ack_q;

  assign ack_s = ack_sync_q[last_stage];

  // phase_q is already stable for a cycle before req rises and does not
  // move again until ack has fallen, so the phase bits are safe to sample
  always_ff @(posedge src_clk_i) begin
    if (rst_i) begin
      phase_q <= clr_idle;
      req_q   <= 1'b0;
      sent_q  <= 1'b0;
    end else begin
      case (phase_q)
        clr_idle: begin
          if (src_clear_i) begin
            phase_q <= clr_isolate;
          end
        end
        clr_isolate: begin
          // new requests are blocked, wait for the last response
          if (idle_i) begin
            phase_q <= clr_clear;
          end
        end
        clr_clear: begin
          // raise req, wait for ack high, drop req, wait for ack low
          if (!sent_q && !req_q && !ack_s) begin
            req_q <= 1'b1;
          end else if (req_q && ack_s) begin
            req_q  <= 1'b0;
            sent_q <= 1'b1;
          end else if (sent_q && !ack_s) begin
            sent_q  <= 1'b0;
            phase_q <= clr_post;
          end
        end
        default: begin
          // post-clear lasts a cycle, then isolation is lifted
          phase_q <= clr_idle;
        end
      endcase
    end
  end

  always_ff @(posedge src_clk_i) begin
    if (rst_i) begin
      ack_sync_q <= '0;
    end else begin
      ack_sync_q[0] <= ack_q;
      for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
        ack_sync_q[i] <= ack_sync_q[i-1];
      end
    end
  end

  // the port stays closed for the whole sequence, post-clear included
  assign isolate_o = (phase_q != clr_idle);
  assign busy_o    = (phase_q != clr_idle);
  // held until ack falls, so it covers the whole destination clear window
  assign src_clr_o = (phase_q == clr_clear);

  always_ff @(posedge dst_clk_i) begin
    if (dst_rst_i) begin
      req_sync_q <= '0;
      ack_q      <= 1'b0;
      for (int i = 0; i < `CDC_SYNC_STAGES; i++) begin
        phase_sync_q[i] <= clr_idle;
      end
    end else begin
      req_sync_q[0]   <= req_q;
      phase_sync_q[0] <= phase_q;
      for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
        req_sync_q[i]   <= req_sync_q[i-1];
        phase_sync_q[i] <= phase_sync_q[i-1];
      end
      // ack trails the request by a cycle so dst_clr_o is seen at least once
      ack_q <= req_sync_q[last_stage];
    end
  end

  assign dst_clr_o = req_sync_q[last_stage] && (phase_sync_q[last_stage] == clr_clear);

endmodule

`default_nettype wire

//--- src/cdc_bridge_top.sv
// clearable AXI-Lite clock domain crossing
// requests enter under src_clk_i and leave under dst_clk_i, responses take
// the reverse path through a second FIFO; a clear request drains the bus
// and empties both FIFOs on both sides in lock step
`timescale 1ns/1ns
`default_nettype none
`include "cdc_defines.svh"

module cdc_bridge_top (
  input  wire logic                src_clk_i,
  input  wire logic                dst_clk_i,
  input  wire logic                rst_i,
  input  wire logic                src_clear_i,
  output logic                     src_clear_busy_o,
  // source side, clocked by src_clk_i
  input  wire logic                src_req_valid_i,
  input  wire cdc_pkg::req_chan_t  src_req_i,
  output logic                     src_req_ready_o,
  output logic                     src_rsp_valid_o,
  output cdc_pkg::rsp_chan_t       src_rsp_o,
  input  wire logic                src_rsp_ready_i,
  // destination side, clocked by dst_clk_i
  output logic                     dst_req_valid_o,
  output cdc_pkg::req_chan_t       dst_req_o,
  input  wire logic                dst_req_ready_i,
  input  wire logic                dst_rsp_valid_i,
  input  wire cdc_pkg::rsp_chan_t  dst_rsp_i,
  output logic                     dst_rsp_ready_o
);
  import cdc_pkg::*;

  // rst_i belongs to the source clock, carry it over before use
  logic [`CDC_SYNC_STAGES-1:0] dst_rst_q;
  logic dst_rst;
  logic req_push_valid;
  logic req_push_ready;
  logic rsp_pop;
  logic iso_idle;
  logic iso_req;
  logic src_clr;
  logic dst_clr;

  always_ff @(posedge dst_clk_i) begin
    dst_rst_q[0] <= rst_i;
    for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
      dst_rst_q[i] <= dst_rst_q[i-1];
    end
  end
  assign dst_rst = dst_rst_q[`CDC_SYNC_STAGES-1];

  // the isolator sees response pops to know when the bus has drained
  assign rsp_pop = src_rsp_valid_o && src_rsp_ready_i;

  cdc_isolate i_isolate (
    .src_clk_i    (src_clk_i),
    .rst_i        (rst_i),
    .isolate_i    (iso_req),
    .req_valid_i  (src_req_valid_i),
    .req_ready_o  (src_req_ready_o),
    .fifo_valid_o (req_push_valid),
    .fifo_ready_i (req_push_ready),
    .rsp_pop_i    (rsp_pop),
    .idle_o       (iso_idle)
  );

  cdc_fifo_gray #(.payload_t(req_chan_t)) i_req_fifo (
    .push_clk_i   (src_clk_i),
    .push_rst_i   (rst_i),
    .push_clr_i   (src_clr),
    .push_valid_i (req_push_valid),
    .push_data_i  (src_req_i),
    .push_ready_o (req_push_ready),
    .pop_clk_i    (dst_clk_i),
    .pop_rst_i    (dst_rst),
    .pop_clr_i    (dst_clr),
    .pop_valid_o  (dst_req_valid_o),
    .pop_data_o   (dst_req_o),
    .pop_ready_i  (dst_req_ready_i)
  );

  cdc_fifo_gray #(.payload_t(rsp_chan_t)) i_rsp_fifo (
    .push_clk_i   (dst_clk_i),
    .push_rst_i   (dst_rst),
    .push_clr_i   (dst_clr),
    .push_valid_i (dst_rsp_valid_i),
    .push_data_i  (dst_rsp_i),
    .push_ready_o (dst_rsp_ready_o),
    .pop_clk_i    (src_clk_i),
    .pop_rst_i    (rst_i),
    .pop_clr_i    (src_clr),
    .pop_valid_o  (src_rsp_valid_o),
    .pop_data_o   (src_rsp_o),
    .pop_ready_i  (src_rsp_ready_i)
  );

  cdc_clear_seq i_clear_seq (
    .src_clk_i   (src_clk_i),
    .rst_i       (rst_i),
    .src_clear_i (src_clear_i),
    .idle_i      (iso_idle),
    .isolate_o   (iso_req),
    .src_clr_o   (src_clr),
    .busy_o      (src_clear_busy_o),
    .dst_clk_i   (dst_clk_i),
    .dst_rst_i   (dst_rst),
    .dst_clr_o   (dst_clr)
  );

endmodule

`default_nettype wire

//--- dv/tb_cdc_bridge.sv
// testbench for the clearable AXI-Lite clock domain crossing
// a stimulus table is applied on the source side, a memory model answers
// on the destination side, and every response is compared in order with
// an expectation built from the memory rules when the request is accepted
`timescale 1ns/1ns
`default_nettype none
`include "cdc_defines.svh"

module tb_cdc_bridge;
  import cdc_pkg::*;

  typedef struct {
    string                  name;
    logic [`CDC_ADDR_W-1:0] addr;
    logic                   write;
    logic [`CDC_DATA_W-1:0] data;
    logic                   clr;
    logic                   bp;
  } tb_entry_t;

  logic      src_clk_i = 1'b0;
  logic      dst_clk_i = 1'b0;
  logic      rst_i;
  logic      src_clear_i;
  logic      src_clear_busy_o;
  logic      src_req_valid_i;
  req_chan_t src_req_i;
  logic      src_req_ready_o;
  logic      src_rsp_valid_o;
  rsp_chan_t src_rsp_o;
  logic      src_rsp_ready_i;
  logic      dst_req_valid_o;
  req_chan_t dst_req_o;
  logic      dst_req_ready_i;
  logic      dst_rsp_valid_i;
  rsp_chan_t dst_rsp_i;
  logic      dst_rsp_ready_o;

  tb_entry_t              tbl [$];
  rsp_chan_t              exp_q [$];
  string                  name_q [$];
  rsp_chan_t              model_q [$];
  logic [`CDC_DATA_W-1:0] ref_mem [logic [`CDC_ADDR_W-1:0]];
  logic [`CDC_DATA_W-1:0] dst_mem [logic [`CDC_ADDR_W-1:0]];
  logic [31:0]            lcg_state = 32'h736;
  logic                   bp_en = 1'b0;
  logic                   busy_prev = 1'b0;
  int                     errors = 0;
  int                     accepted = 0;
  int                     rsp_count = 0;
  int                     clears_seen = 0;
  int                     clears_asked = 0;

  // the two clocks never share an edge, so both sides may draw from one LCG
  always #2 src_clk_i = ~src_clk_i;
  always #3 dst_clk_i = ~dst_clk_i;

  cdc_bridge_top u_dut (
    .src_clk_i        (src_clk_i),
    .dst_clk_i        (dst_clk_i),
    .rst_i            (rst_i),
    .src_clear_i      (src_clear_i),
    .src_clear_busy_o (src_clear_busy_o),
    .src_req_valid_i  (src_req_valid_i),
    .src_req_i        (src_req_i),
    .src_req_ready_o  (src_req_ready_o),
    .src_rsp_valid_o  (src_rsp_valid_o),
    .src_rsp_o        (src_rsp_o),
    .src_rsp_ready_i  (src_rsp_ready_i),
    .dst_req_valid_o  (dst_req_valid_o),
    .dst_req_o        (dst_req_o),
    .dst_req_ready_i  (dst_req_ready_i),
    .dst_rsp_valid_i  (dst_rsp_valid_i),
    .dst_rsp_i        (dst_rsp_i),
    .dst_rsp_ready_o  (dst_rsp_ready_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // a ready input is low for roughly three draws in eight under back-pressure
  function automatic logic draw_ready();
    lcg_state = lcg_next(lcg_state);
    return !bp_en || (lcg_state[31:29] > 3'd2);
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic add_entry(input string name, input logic [`CDC_ADDR_W-1:0] addr,
                           input logic write, input logic [`CDC_DATA_W-1:0] data,
                           input logic clr, input logic bp);
    tb_entry_t e;
    e.name  = name;
    e.addr  = addr;
    e.write = write;
    e.data  = data;
    e.clr   = clr;
    e.bp    = bp;
    tbl.push_back(e);
    if (clr) begin
      clears_asked++;
    end
  endtask

  // reads of unwritten words give zero and address zero refuses writes
  task automatic expect_response(input tb_entry_t e);
    rsp_chan_t r;
    r.rdata = '0;
    r.err   = 1'b0;
    if (e.write) begin
      if (e.addr == '0) begin
        r.err = 1'b1;
      end else begin
        ref_mem[e.addr] = e.data;
      end
    end else if (ref_mem.exists(e.addr)) begin
      r.rdata = ref_mem[e.addr];
    end
    exp_q.push_back(r);
    name_q.push_back(e.name);
  endtask

  // the destination memory model stores whole words, as every strobe is driven high
  task automatic serve_request(input req_chan_t q, output rsp_chan_t a);
    a.rdata = '0;
    a.err   = 1'b0;
    if (q.write && q.addr == '0) begin
      a.err = 1'b1;
    end else if (q.write) begin
      dst_mem[q.addr] = q.wdata;
    end else if (dst_mem.exists(q.addr)) begin
      a.rdata = dst_mem[q.addr];
    end
  endtask

  // starts 1 ns after a source edge and returns 1 ns after the accepting edge
  task automatic apply_entry(input tb_entry_t e);
    logic taken;
    if (e.clr) begin
      src_clear_i = 1'b1;
      @(posedge src_clk_i);
      #1 src_clear_i = 1'b0;
    end
    bp_en             = e.bp;
    src_req_i.addr    = e.addr;
    src_req_i.write   = e.write;
    src_req_i.wdata   = e.data;
    src_req_i.strb    = '1;
    src_req_valid_i   = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(posedge src_clk_i);
      taken = src_req_ready_o;
    end
    accepted++;
    expect_response(e);
    #1 src_req_valid_i = 1'b0;
  endtask

  // the memory model samples on the destination edge and drives 1 ns after it
  always @(posedge dst_clk_i) begin : dst_side
    rsp_chan_t a;
    if (!rst_i && dst_req_valid_o && dst_req_ready_i) begin
      check("dst req strobes", {(`CDC_DATA_W/8){1'b1}}, dst_req_o.strb);
      serve_request(dst_req_o, a);
      model_q.push_back(a);
    end
    if (!rst_i && dst_rsp_valid_i && dst_rsp_ready_o) begin
      void'(model_q.pop_front());
    end
    #1;
    dst_req_ready_i = draw_ready();
    dst_rsp_valid_i = (model_q.size() > 0);
    if (model_q.size() > 0) begin
      dst_rsp_i = model_q[0];
    end
  end

  // responses are checked in order, and the request gate while a clear runs
  always @(posedge src_clk_i) begin : src_side
    rsp_chan_t r;
    string     nm;
    if (!rst_i && src_rsp_valid_o && src_rsp_ready_i) begin
      rsp_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("a response arrived with no request outstanding");
      end else begin
        r  = exp_q.pop_front();
        nm = name_q.pop_front();
        check(nm, r, src_rsp_o);
      end
    end
    if (!rst_i && src_clear_busy_o) begin
      check("request gate during clear", 1'b0, src_req_ready_o);
    end
    if (!rst_i && src_clear_busy_o && !busy_prev) begin
      clears_seen++;
    end
    busy_prev = src_clear_busy_o;
    #1 src_rsp_ready_i = draw_ready();
  end

  initial begin : watchdog
    int limit;
    int cycles;
    cycles = 0;
    @(posedge src_clk_i);
    limit = tbl.size() * 200 + 8;
    while (cycles < limit) begin
      @(posedge src_clk_i);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d source cycles", limit);
    $display("Checks failed");
    $finish;
  end

  initial begin : main
    rst_i           = 1'b1;
    src_clear_i     = 1'b0;
    src_req_valid_i = 1'b0;
    src_req_i       = '0;
    src_rsp_ready_i = 1'b1;
    dst_req_ready_i = 1'b1;
    dst_rsp_valid_i = 1'b0;
    dst_rsp_i       = '0;

    //         name          addr      wr    data           clr   bp
    add_entry("wr_a",       16'h0010, 1'b1, 32'h1111_1111, 1'b0, 1'b0);
    add_entry("wr_b",       16'h0024, 1'b1, 32'hdead_beef, 1'b0, 1'b0);
    add_entry("rd_a",       16'h0010, 1'b0, 32'h0,         1'b0, 1'b0);
    add_entry("rd_b",       16'h0024, 1'b0, 32'h0,         1'b0, 1'b0);
    add_entry("wr_zero",    16'h0000, 1'b1, 32'h5555_aaaa, 1'b0, 1'b0);
    add_entry("rd_zero",    16'h0000, 1'b0, 32'h0,         1'b0, 1'b0);
    add_entry("rd_unwr",    16'h0100, 1'b0, 32'h0,         1'b0, 1'b0);
    add_entry("bp_wr_c",    16'h0030, 1'b1, 32'ha5a5_5a5a, 1'b0, 1'b1);
    add_entry("bp_wr_d",    16'h0034, 1'b1, 32'h0123_4567, 1'b0, 1'b1);
    add_entry("bp_rd_c",    16'h0030, 1'b0, 32'h0,         1'b0, 1'b1);
    add_entry("bp_rd_d",    16'h0034, 1'b0, 32'h0,         1'b0, 1'b1);
    add_entry("bp_rd_a",    16'h0010, 1'b0, 32'h0,         1'b0, 1'b1);
    add_entry("clr_rd_b",   16'h0024, 1'b0, 32'h0,         1'b1, 1'b0);
    add_entry("post_wr_e",  16'h0040, 1'b1, 32'hcafe_f00d, 1'b0, 1'b0);
    add_entry("post_rd_e",  16'h0040, 1'b0, 32'h0,         1'b0, 1'b0);
    add_entry("post_rd_c",  16'h0030, 1'b0, 32'h0,         1'b0, 1'b0);
    add_entry("clr_bp_wr",  16'h0044, 1'b1, 32'h8765_4321, 1'b1, 1'b1);
    add_entry("clr_bp_rd",  16'h0044, 1'b0, 32'h0,         1'b0, 1'b1);

    repeat (8) @(posedge src_clk_i);
    #1 rst_i = 1'b0;
    @(posedge src_clk_i);
    check("reset req ready", 1'b1, src_req_ready_o);
    check("reset rsp valid", 1'b0, src_rsp_valid_o);
    check("reset dst req valid", 1'b0, dst_req_valid_o);
    check("reset clear busy", 1'b0, src_clear_busy_o);
    #1;

    foreach (tbl[i]) begin
      apply_entry(tbl[i]);
    end

    // wait for the drain, then linger so a stale FIFO entry would still show up
    while (exp_q.size() > 0) begin
      @(posedge src_clk_i);
    end
    bp_en = 1'b0;
    repeat (40) @(posedge src_clk_i);
    check("response count", accepted, rsp_count);
    check("clears seen", clears_asked, clears_seen);
    check("clear busy at end", 1'b0, src_clear_busy_o);

    $display("errors: %0d, requests accepted: %0d, responses: %0d",
             errors, accepted, rsp_count);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
src/cdc_pkg.sv
src/cdc_fifo_gray.sv
src/cdc_isolate.sv
src/cdc_clear_seq.sv
src/cdc_bridge_top.sv
dv/tb_cdc_bridge.sv

//--- Bender.yml
package:
  name: cdc_bridge

sources:
  - include_dirs:
      - include
    files:
      - src/cdc_pkg.sv
      - src/cdc_fifo_gray.sv
      - src/cdc_isolate.sv
      - src/cdc_clear_seq.sv
      - src/cdc_bridge_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_cdc_bridge.sv
